// ==== hdl/br_cluster.sv ====
`default_nettype none

module br_cluster import br_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       in_valid,
    input  wire br_uop_t    in_uop,
    input  wire wb_bus_t    wb,
    input  wire logic       ext_flush,
    output      br_result_t result,
    output      logic       stall
);

    logic             disp_valid;
    br_uop_t          disp_uop;
    logic             flush;
    logic [PTR_W-1:0] count;
    logic             iss_valid;
    br_issue_t        iss_uop;
    logic [TAG_W-1:0] rd_tag1;
    logic [TAG_W-1:0] rd_tag2;
    logic [XLEN-1:0]  rd_data1;
    logic [XLEN-1:0]  rd_data2;
    wb_t              link_wb;       // fourth broadcast, from jumps

    br_dispatch u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .wb         (wb),
        .link_wb    (link_wb),
        .ext_flush  (ext_flush),
        .mispredict (result.mispredict),
        .count      (count),
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .flush      (flush),
        .stall      (stall)
    );

    br_station u_station (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .wb         (wb),
        .link_wb    (link_wb),
        .count      (count),
        .iss_valid  (iss_valid),
        .iss_uop    (iss_uop)
    );

    phys_regfile u_prf (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .link_wb  (link_wb),
        .rd_tag1  (rd_tag1),
        .rd_tag2  (rd_tag2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    br_resolve u_resolve (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss_uop   (iss_uop),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .rd_tag1   (rd_tag1),
        .rd_tag2   (rd_tag2),
        .result    (result),
        .link_wb   (link_wb)
    );

endmodule

`default_nettype wire

// ==== hdl/br_dispatch.sv ====
`default_nettype none

module br_dispatch import br_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire br_uop_t          in_uop,
    input  wire wb_bus_t          wb,
    input  wire wb_t              link_wb,
    input  wire logic             ext_flush,
    input  wire logic             mispredict,
    input  wire logic [PTR_W-1:0] count,
    output      logic             disp_valid,
    output      br_uop_t          disp_uop,
    output      logic             flush,
    output      logic             stall
);

    br_uop_t        snooped;
    logic [PTR_W:0] occupancy;   // station entries plus the one held here

    // exception, mret or a resolved mispredict
    assign flush = ext_flush | mispredict;

    // catch a broadcast landing on the same edge as the uop
    always_comb begin
        snooped      = in_uop;
        snooped.rdy1 = in_uop.rdy1 | wb_match(wb, link_wb, in_uop.src1);
        snooped.rdy2 = in_uop.rdy2 | wb_match(wb, link_wb, in_uop.src2);
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            disp_uop <= snooped;
        end
    end

    assign occupancy = {1'b0, count} + {{PTR_W{1'b0}}, disp_valid};

    // keep one slot of slack for the uop sampled while stall rises
    assign stall = (occupancy >= (PTR_W + 1)'(RS_DEPTH - 1));

endmodule

`default_nettype wire

// ==== hdl/br_pkg.sv ====
`default_nettype none

package br_pkg;

    localparam int XLEN     = 32;
    localparam int TAG_W    = 8;
    localparam int RS_DEPTH = 16;
    localparam int PTR_W    = 5;           // one extra bit tells full from empty
    localparam int RS_IDX_W = PTR_W - 1;
    localparam int NUM_WB   = 3;           // alu, mul, load
    localparam int PRF_SIZE = 256;

    // branch funct3 encodings
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // renamed branch or jump as it leaves rename
    typedef struct packed {
        logic [31:0]      inst_num;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  imm;
        logic [TAG_W-1:0] rd;
        logic [TAG_W-1:0] src1;
        logic [TAG_W-1:0] src2;
        logic             rdy1;
        logic             rdy2;
        logic             jump;          // jal, always taken
        logic [2:0]       funct3;
        logic             pred_taken;
        logic             pred_hit;      // btb hit at fetch
    } br_uop_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } wb_t;

    typedef wb_t [NUM_WB-1:0] wb_bus_t;

    // what resolve needs, ready bits dropped
    typedef struct packed {
        logic [31:0]      inst_num;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  imm;
        logic [TAG_W-1:0] rd;
        logic [TAG_W-1:0] src1;
        logic [TAG_W-1:0] src2;
        logic             jump;
        logic [2:0]       funct3;
        logic             pred_taken;
        logic             pred_hit;
    } br_issue_t;

    typedef struct packed {
        logic             valid;
        logic [31:0]      inst_num;
        logic             taken;
        logic             mispredict;
        logic [XLEN-1:0]  redirect_pc;
    } br_result_t;

    // true when any valid broadcast carries this tag
    function automatic logic wb_match(input wb_bus_t wb, input wb_t link,
                                      input logic [TAG_W-1:0] tag);
        logic hit;
        hit = link.valid && (link.tag == tag);
        for (int i = 0; i < NUM_WB; i++) begin
            hit = hit | (wb[i].valid && (wb[i].tag == tag));
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/br_resolve.sv ====
`default_nettype none

module br_resolve import br_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             flush,
    input  wire logic             iss_valid,
    input  wire br_issue_t        iss_uop,
    input  wire logic [XLEN-1:0]  rd_data1,
    input  wire logic [XLEN-1:0]  rd_data2,
    output      logic [TAG_W-1:0] rd_tag1,
    output      logic [TAG_W-1:0] rd_tag2,
    output      br_result_t       result,
    output      wb_t              link_wb
);

    logic            cond;
    logic            taken;
    logic            mispredict;
    logic            fire;
    logic [XLEN-1:0] target_pc;
    logic [XLEN-1:0] seq_pc;

    assign rd_tag1 = iss_uop.src1;
    assign rd_tag2 = iss_uop.src2;

    always_comb begin
        case (iss_uop.funct3)
            F3_BEQ:  cond = (rd_data1 == rd_data2);
            F3_BNE:  cond = (rd_data1 != rd_data2);
            F3_BLT:  cond = ($signed(rd_data1) <  $signed(rd_data2));
            F3_BGE:  cond = ($signed(rd_data1) >= $signed(rd_data2));
            F3_BLTU: cond = (rd_data1 <  rd_data2);
            F3_BGEU: cond = (rd_data1 >= rd_data2);
            default: cond = 1'b0;   // reserved funct3 never taken
        endcase
    end

    assign taken     = iss_uop.jump | cond;
    assign target_pc = iss_uop.pc + iss_uop.imm;
    assign seq_pc    = iss_uop.pc + XLEN'(4);

    // a taken branch without a btb hit had no target at fetch
    assign mispredict = (taken != iss_uop.pred_taken) || (taken && !iss_uop.pred_hit);

    // drop whatever issued alongside a flush
    assign fire = iss_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid      <= 1'b0;
            result.mispredict <= 1'b0;
            link_wb.valid     <= 1'b0;
        end else begin
            result.valid      <= fire;
            result.mispredict <= fire && mispredict;   // feeds flush directly
            link_wb.valid     <= fire && iss_uop.jump;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            result.inst_num    <= iss_uop.inst_num;
            result.taken       <= taken;
            result.redirect_pc <= taken ? target_pc : seq_pc;
            link_wb.tag        <= iss_uop.rd;
            link_wb.data       <= seq_pc;      // return address of the jump
        end
    end

endmodule

`default_nettype wire

// ==== hdl/br_station.sv ====
`default_nettype none

module br_station import br_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             flush,
    input  wire logic             disp_valid,
    input  wire br_uop_t          disp_uop,
    input  wire wb_bus_t          wb,
    input  wire wb_t              link_wb,
    output      logic [PTR_W-1:0] count,
    output      logic             iss_valid,
    output      br_issue_t        iss_uop
);

    br_uop_t              entries [RS_DEPTH];
    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [RS_IDX_W-1:0]  head_idx;
    logic [RS_IDX_W-1:0]  tail_idx;
    logic                 head_ready;
    br_uop_t              wr_uop;

    function automatic br_issue_t to_issue(input br_uop_t u);
        br_issue_t s;
        s.inst_num   = u.inst_num;
        s.pc         = u.pc;
        s.imm        = u.imm;
        s.rd         = u.rd;
        s.src1       = u.src1;
        s.src2       = u.src2;
        s.jump       = u.jump;
        s.funct3     = u.funct3;
        s.pred_taken = u.pred_taken;
        s.pred_hit   = u.pred_hit;
        return s;
    endfunction

    assign head_idx = head[RS_IDX_W-1:0];
    assign tail_idx = tail[RS_IDX_W-1:0];
    assign count    = tail - head;          // wraps with the extra pointer bit

    // only the oldest entry may go, keeps branches in order
    assign head_ready = (head != tail) && entries[head_idx].rdy1 && entries[head_idx].rdy2;

    // entry being written also sees this edge's broadcasts
    always_comb begin
        wr_uop      = disp_uop;
        wr_uop.rdy1 = disp_uop.rdy1 | wb_match(wb, link_wb, disp_uop.src1);
        wr_uop.rdy2 = disp_uop.rdy2 | wb_match(wb, link_wb, disp_uop.src2);
    end

    // entry storage and tag wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wb_match(wb, link_wb, entries[i].src1)) begin
                entries[i].rdy1 <= 1'b1;
            end
            if (wb_match(wb, link_wb, entries[i].src2)) begin
                entries[i].rdy2 <= 1'b1;
            end
        end
        if (disp_valid) begin
            entries[tail_idx] <= wr_uop;   // overrides the loop for this slot
        end
    end

    // pointers and issue strobe
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head      <= '0;
            tail      <= '0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= head_ready;
            if (disp_valid) begin
                tail <= tail + 1'b1;
            end
            if (head_ready) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (head_ready) begin
            iss_uop <= to_issue(entries[head_idx]);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phys_regfile.sv ====
`default_nettype none

module phys_regfile import br_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire wb_bus_t          wb,
    input  wire wb_t              link_wb,
    input  wire logic [TAG_W-1:0] rd_tag1,
    input  wire logic [TAG_W-1:0] rd_tag2,
    output      logic [XLEN-1:0]  rd_data1,
    output      logic [XLEN-1:0]  rd_data2
);

    logic [XLEN-1:0] regs [PRF_SIZE];

    // forward a write landing this cycle, same priority as the write loop
    function automatic logic [XLEN-1:0] bypass(input logic [TAG_W-1:0] tag,
                                               input logic [XLEN-1:0] stored,
                                               input wb_bus_t         wb_in,
                                               input wb_t             link_in);
        logic [XLEN-1:0] val;
        val = stored;
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_in[i].valid && (wb_in[i].tag == tag)) begin
                val = wb_in[i].data;
            end
        end
        if (link_in.valid && (link_in.tag == tag)) begin
            val = link_in.data;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PRF_SIZE; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_WB; i++) begin
                if (wb[i].valid) begin
                    regs[wb[i].tag] <= wb[i].data;
                end
            end
            if (link_wb.valid) begin
                regs[link_wb.tag] <= link_wb.data;   // link port last
            end
        end
    end

    assign rd_data1 = bypass(rd_tag1, regs[rd_tag1], wb, link_wb);
    assign rd_data2 = bypass(rd_tag2, regs[rd_tag2], wb, link_wb);

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/br_pkg.sv
hdl/br_dispatch.sv
hdl/br_station.sv
hdl/phys_regfile.sv
hdl/br_resolve.sv
hdl/br_cluster.sv
tb/tb_br_cluster.sv

// ==== tb/tb_br_cluster.sv ====
`default_nettype none

module tb_br_cluster import br_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       in_valid;
    br_uop_t    in_uop;
    wb_bus_t    wb;
    logic       ext_flush;
    br_result_t result;
    logic       stall;

    logic [XLEN-1:0] prf_model [PRF_SIZE];   // values the testbench broadcast
    br_result_t      res_q [$];
    int              cyc_q [$];
    int              cycle = 0;
    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    integer          seed;

    br_cluster UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .wb        (wb),
        .ext_flush (ext_flush),
        .result    (result),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // collect results mid-cycle, away from the edge
    always @(negedge clk) begin
        if (!rst && result.valid === 1'b1) begin
            res_q.push_back(result);
            cyc_q.push_back(cycle);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_result(input br_result_t got, input br_result_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $write("FAILED @%0t: %s: got inst %0d taken %b misp %b pc %h", $time, what,
                   got.inst_num, got.taken, got.mispredict, got.redirect_pc);
            $display(", expected inst %0d taken %b misp %b pc %h",
                     exp.inst_num, exp.taken, exp.mispredict, exp.redirect_pc);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic br_uop_t make_branch(input logic [31:0] inst, input logic [XLEN-1:0] pc,
                                            input logic [XLEN-1:0] imm,
                                            input logic [TAG_W-1:0] src1,
                                            input logic [TAG_W-1:0] src2,
                                            input logic r1, input logic r2,
                                            input logic [2:0] f3, input logic pred);
        br_uop_t u;
        u            = '0;
        u.inst_num   = inst;
        u.pc         = pc;
        u.imm        = imm;
        u.src1       = src1;
        u.src2       = src2;
        u.rdy1       = r1;
        u.rdy2       = r2;
        u.funct3     = f3;
        u.pred_taken = pred;
        u.pred_hit   = 1'b1;
        return u;
    endfunction

    // flip the sign bits so an unsigned compare orders two's complement values
    function automatic logic signed_less(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    // reference outcome from the operand values held in prf_model
    function automatic br_result_t expect_of(input br_uop_t u);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            tk;
        br_result_t      r;
        a = prf_model[u.src1];
        b = prf_model[u.src2];
        case (u.funct3)
            F3_BEQ:  tk = (a == b);
            F3_BNE:  tk = (a != b);
            F3_BLT:  tk = signed_less(a, b);
            F3_BGE:  tk = !signed_less(a, b);
            F3_BLTU: tk = (a < b);
            F3_BGEU: tk = !(a < b);
            default: tk = 1'b0;
        endcase
        if (u.jump) tk = 1'b1;
        r.valid       = 1'b1;
        r.inst_num    = u.inst_num;
        r.taken       = tk;
        r.mispredict  = tk ? !(u.pred_taken && u.pred_hit) : u.pred_taken;
        r.redirect_pc = tk ? u.pc + u.imm : u.pc + 32'd4;
        return r;
    endfunction

    task automatic write_reg(input int port, input logic [TAG_W-1:0] tag,
                             input logic [XLEN-1:0] val);
        wb[port].valid = 1'b1;
        wb[port].tag   = tag;
        wb[port].data  = val;
        prf_model[tag] = val;
        next_cycle();
        wb[port] = '0;
    endtask

    task automatic send_uop(input br_uop_t u, output int at);
        in_valid = 1'b1;
        in_uop   = u;
        at       = cycle;   // sampled on the coming edge
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic wait_result(output br_result_t r, output int at, input string what);
        int n;
        r  = '0;
        at = -1;
        n  = 0;
        while (res_q.size() == 0 && n < 40) begin
            next_cycle();
            n++;
        end
        if (res_q.size() == 0) begin
            errors++;
            $display("timeout: no result for %s within 40 cycles", what);
        end else begin
            r  = res_q.pop_front();
            at = cyc_q.pop_front();
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        br_result_t r;
        repeat (cycles) next_cycle();
        checks++;
        while (res_q.size() > 0) begin
            r = res_q.pop_front();
            void'(cyc_q.pop_front());
            errors++;
            $display("unexpected result for inst %0d during %s", r.inst_num, what);
        end
    endtask

    task automatic run_branch(input br_uop_t u, input string what, output int latency);
        br_result_t got;
        int         sent;
        int         at;
        send_uop(u, sent);
        wait_result(got, at, what);
        check_result(got, expect_of(u), what);
        latency = at - sent - 1;   // edges after the one that took in_valid
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) $display("test %0d %s: ok", tests, name);
        else $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    task automatic ready_operands();
        int      e0;
        int      lat;
        br_uop_t u;
        e0 = errors;
        write_reg(0, 10, 32'h1234_5678);
        write_reg(1, 11, 32'h1234_5678);
        write_reg(2, 12, 32'h0bad_cafe);
        u = make_branch(100, 32'h1000, 32'h40, 10, 11, 1, 1, F3_BEQ, 1);
        run_branch(u, "beq taken", lat);
        check_count(lat, 3, "beq taken latency");
        u = make_branch(101, 32'h2000, 32'hffff_fff0, 10, 12, 1, 1, F3_BEQ, 0);
        run_branch(u, "beq not taken", lat);
        check_count(lat, 3, "beq not taken latency");
        report_test("ready operands", e0);
    endtask

    task automatic all_conditions();
        int              e0;
        int              lat;
        logic [2:0]      codes [6];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
        br_uop_t         u;
        e0    = errors;
        codes = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                a = $random(seed);
                b = $random(seed);
                if (k == 0) begin
                    a = 32'h8000_0000;   // negative signed, large unsigned
                    b = 32'h0000_0001;
                end
                if (k == 1) b = a;
                write_reg(0, 20, a);
                write_reg(1, 21, b);
                pc = $random(seed);
                pc[1:0] = 2'b00;
                u = make_branch(200 + i * 4 + k, pc, $random(seed), 20, 21, 1, 1,
                                codes[i], 1'($random(seed)));
                u.pred_hit = (k != 1);   // btb miss on the equal-operand case
                run_branch(u, "condition", lat);
                check_count(lat, 3, "condition latency");
            end
        end
        report_test("all conditions", e0);
    endtask

    task automatic wakeup_order();
        int              e0;
        int              t;
        logic [XLEN-1:0] v;
        br_uop_t         older;
        br_uop_t         younger;
        br_result_t      got;
        e0 = errors;
        v  = $random(seed);
        write_reg(1, 31, v);
        older   = make_branch(300, 32'h3000, 32'h100, 30, 31, 0, 1, F3_BEQ, 1);
        younger = make_branch(301, 32'h3100, 32'h20, 31, 31, 1, 1, F3_BNE, 0);
        send_uop(older, t);
        send_uop(younger, t);
        expect_quiet(8, "wait on tag 30");
        write_reg(2, 30, v);
        wait_result(got, t, "woken branch");
        check_result(got, expect_of(older), "woken branch");
        wait_result(got, t, "queued branch");
        check_result(got, expect_of(younger), "queued branch");
        report_test("wakeup and order", e0);
    endtask

    task automatic mispredict_flush();
        int         e0;
        int         t;
        br_uop_t    m;
        br_result_t got;
        e0 = errors;
        // taken while predicted not taken
        m  = make_branch(400, 32'h4000, 32'h800, 10, 11, 1, 1, F3_BEQ, 0);
        send_uop(m, t);
        for (int i = 1; i <= 3; i++) begin
            send_uop(make_branch(400 + i, 32'h4000 + 4 * i, 32'h10, 10, 12, 1, 1, F3_BNE, 1), t);
        end
        wait_result(got, t, "mispredicted branch");
        check_result(got, expect_of(m), "mispredicted branch");
        expect_quiet(12, "after mispredict");
        report_test("mispredict flush", e0);
    endtask

    task automatic link_wakeup();
        int         e0;
        int         t;
        br_uop_t    j;
        br_uop_t    b;
        br_result_t got;
        e0 = errors;
        j  = make_branch(500, 32'h5000, 32'h200, 0, 0, 1, 1, F3_BEQ, 1);
        j.jump = 1'b1;
        j.rd   = 40;
        write_reg(0, 41, 32'h5004);
        b = make_branch(501, 32'h5200, 32'h30, 40, 41, 0, 1, F3_BEQ, 1);
        send_uop(j, t);
        send_uop(b, t);
        wait_result(got, t, "jump");
        check_result(got, expect_of(j), "jump");
        prf_model[40] = j.pc + 32'd4;   // link value
        wait_result(got, t, "beq on link");
        check_result(got, expect_of(b), "beq on link");
        report_test("link wakeup", e0);
    endtask

    task automatic flush_and_stall();
        int      e0;
        int      t;
        int      sent;
        int      lat;
        br_uop_t u;
        e0   = errors;
        sent = 0;
        while (!stall && sent < RS_DEPTH + 4) begin
            send_uop(make_branch(600 + sent, 32'h6000, 32'h8, 50, 51, 0, 1, F3_BEQ, 1), t);
            sent++;
        end
        check_level(stall, 1'b1, "stall with full station");
        check_count(sent, RS_DEPTH - 1, "entries accepted before stall");
        ext_flush = 1'b1;
        next_cycle();
        ext_flush = 1'b0;
        check_level(stall, 1'b0, "stall after ext_flush");
        write_reg(0, 50, 32'h77);   // would wake the dropped entries
        expect_quiet(10, "after ext_flush");
        u = make_branch(650, 32'h6800, 32'h44, 10, 12, 1, 1, F3_BLTU, 0);
        u.pred_taken = expect_of(u).taken;
        run_branch(u, "branch after flush", lat);
        check_count(lat, 3, "latency after flush");
        report_test("external flush and stall", e0);
    endtask

    initial begin
        seed      = 46;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_uop    = '0;
        wb        = '0;
        ext_flush = 1'b0;
        for (int r = 0; r < PRF_SIZE; r++) prf_model[r] = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        check_level(result.valid, 1'b0, "result.valid after reset");
        check_level(stall, 1'b0, "stall after reset");
        ready_operands();
        all_conditions();
        wakeup_order();
        mispredict_flush();
        link_wakeup();
        flush_and_stall();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
